//--- build.f
+incdir+common
common/icache_cfg_pkg.sv
common/icache_msg_pkg.sv
icache/icache_data_array.sv
icache/icache_tag_lookup.sv
icache/icache_tag_verify.sv
icache/icache_top.sv
tests/icache_sva.sv
tests/icache_checker.sv
tests/icache_tb.sv

//--- Bender.yml
package:
  name: icache

export_include_dirs:
  - common

sources:
  - files:
      - common/icache_cfg_pkg.sv
      - common/icache_msg_pkg.sv
      - icache/icache_data_array.sv
      - icache/icache_tag_lookup.sv
      - icache/icache_tag_verify.sv
      - icache/icache_top.sv
  - target: test
    files:
      - tests/icache_sva.sv
      - tests/icache_checker.sv
      - tests/icache_tb.sv

//--- tests/icache_tb.sv
// Testbench: clock, reset, memory responder and the stimulus table
`default_nettype none

module icache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import icache_msg_pkg::*;

  localparam logic [31:0] pattern_key = 32'h5a5a_c3c3;
  localparam int          timeout     = 200;
  localparam int          n_entries   = 16;

  typedef struct packed
  {
    logic        clear;
    logic [31:0] addr;
    logic        way;
    logic [3:0]  reps;
    logic        b2b;
  } entry_s;

  logic       clk_i;
  logic       reset_i;
  fetch_pkt_s fetch_pkt_i;
  logic       fetch_v_i;
  logic       ready_o;
  logic [31:0] instr_o;
  logic       data_v_o;
  logic       miss_v_o;
  cache_req_s cache_req_o;
  logic       cache_req_v_o;
  logic       cache_req_yumi_i;
  fill_pkt_s  fill_pkt_i;
  logic       fill_v_i;
  int         chk_errors;
  int         chk_checks;
  int         tb_errors;

  // Clear, address, way, repeat count, back to back
  entry_s table_m [n_entries] = '{
    '{1'b0, 32'h0000_1000, 1'b0, 4'd2, 1'b0},
    '{1'b0, 32'h0000_2010, 1'b0, 4'd1, 1'b0},
    '{1'b0, 32'h0000_1004, 1'b0, 4'd1, 1'b1},
    '{1'b0, 32'h0000_2014, 1'b0, 4'd1, 1'b1},
    '{1'b0, 32'h0000_1008, 1'b0, 4'd1, 1'b1},
    '{1'b0, 32'h0000_201c, 1'b0, 4'd1, 1'b0},
    '{1'b0, 32'h0000_3020, 1'b0, 4'd1, 1'b1},
    '{1'b0, 32'h0000_100c, 1'b0, 4'd1, 1'b0},
    '{1'b0, 32'h0000_3024, 1'b0, 4'd1, 1'b0},
    '{1'b0, 32'h0000_a050, 1'b0, 4'd1, 1'b0},
    '{1'b0, 32'h0000_b050, 1'b0, 4'd1, 1'b0},
    '{1'b0, 32'h0000_a054, 1'b0, 4'd1, 1'b0},
    '{1'b0, 32'h0000_c050, 1'b0, 4'd1, 1'b0},
    '{1'b0, 32'h0000_b058, 1'b0, 4'd2, 1'b0},
    '{1'b1, 32'h0000_1000, 1'b0, 4'd1, 1'b0},
    '{1'b0, 32'h0000_1008, 1'b0, 4'd2, 1'b0}
  };

  icache_top DUT (.*);

  icache_checker #(.pattern_key(pattern_key)) scoreboard
    (.clk_i           (clk_i)
     ,.reset_i         (reset_i)
     ,.fetch_pkt_i     (fetch_pkt_i)
     ,.fetch_v_i       (fetch_v_i)
     ,.ready_i         (ready_o)
     ,.instr_i         (instr_o)
     ,.data_v_i        (data_v_o)
     ,.miss_v_i        (miss_v_o)
     ,.cache_req_i     (cache_req_o)
     ,.cache_req_v_i   (cache_req_v_o)
     ,.cache_req_yumi_i(cache_req_yumi_i)
     ,.fill_pkt_i      (fill_pkt_i)
     ,.fill_v_i        (fill_v_i)
     ,.errors_o        (chk_errors)
     ,.checks_o        (chk_checks)
     );

  always #50 clk_i = ~clk_i;

  // Each word holds its own address XOR a key
  function automatic logic [127:0] block_for(logic [31:0] addr);
    logic [127:0] b;
    for (int i = 0; i < 4; i++)
    begin
      b[i*32 +: 32] = {addr[31:4], i[1:0], 2'b00} ^ pattern_key;
    end
    return b;
  endfunction

  task automatic issue_fetch(input logic [31:0] addr);
    int t;
    fetch_pkt_i <= '{addr: addr};
    fetch_v_i   <= 1'b1;
    for (t = 0; t < timeout; t++)
    begin
      @(posedge clk_i);
      if (ready_o)
        break;
    end
    if (t == timeout)
    begin
      tb_errors++;
      $display("Fetch of %h was never accepted", addr);
    end
  endtask

  // Idle means ready for a few cycles with no refill under way
  task automatic wait_idle();
    int t;
    int quiet;
    quiet = 0;
    for (t = 0; t < timeout; t++)
    begin
      @(posedge clk_i);
      if (ready_o && !cache_req_v_o && !fill_v_i)
        quiet++;
      else
        quiet = 0;
      if (quiet >= 4)
        break;
    end
    if (t == timeout)
    begin
      tb_errors++;
      $display("Cache did not return to idle");
    end
  endtask

  task automatic clear_way(input logic [31:0] addr, input logic way);
    fill_pkt_i <= '{op: e_clear_way, index: addr[7:4], way: way, tag: '0, data: '0};
    fill_v_i   <= 1'b1;
    @(posedge clk_i);
    fill_v_i   <= 1'b0;
  endtask

  //////////////////////////////
  // Memory responder
  //////////////////////////////

  initial
  begin
    int unsigned delay;
    cache_req_s  req;
    void'($urandom(32'heb371923));
    forever
    begin
      @(posedge clk_i);
      if (!reset_i && cache_req_v_o && !cache_req_yumi_i)
      begin
        delay = $urandom_range(5, 0);
        repeat (delay) @(posedge clk_i);
        req = cache_req_o;
        cache_req_yumi_i <= 1'b1;
        @(posedge clk_i);
        cache_req_yumi_i <= 1'b0;
        fill_pkt_i <= '{op: e_fill_line, index: req.addr[7:4], way: req.way,
                        tag: req.addr[31:8], data: block_for(req.addr)};
        fill_v_i   <= 1'b1;
        @(posedge clk_i);
        fill_v_i   <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    fetch_pkt_i      = '0;
    fetch_v_i        = 1'b0;
    cache_req_yumi_i = 1'b0;
    fill_pkt_i       = '0;
    fill_v_i         = 1'b0;
    tb_errors        = 0;
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    wait_idle();

    foreach (table_m[e])
    begin
      if (table_m[e].clear)
      begin
        clear_way(table_m[e].addr, table_m[e].way);
        wait_idle();
      end
      else
      begin
        for (int r = 0; r < table_m[e].reps; r++)
        begin
          issue_fetch(table_m[e].addr);
          if (!table_m[e].b2b)
          begin
            fetch_v_i <= 1'b0;
            wait_idle();
          end
        end
      end
    end

    fetch_v_i <= 1'b0;
    wait_idle();
    $display("checks %0d, checker errors %0d, testbench errors %0d, assertion failures %0d",
             chk_checks, chk_errors, tb_errors, DUT.sva.fail_count);
    if ((chk_errors == 0) && (tb_errors == 0) && (DUT.sva.fail_count == 0))
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/icache_checker.sv
// Reference model of tags, valid and LRU bits, and comparison of the DUT results
`default_nettype none

module icache_checker
  #(parameter logic [31:0] pattern_key = 32'h0)
  (input  logic                         clk_i
   , input  logic                       reset_i
   , input  icache_msg_pkg::fetch_pkt_s fetch_pkt_i
   , input  logic                       fetch_v_i
   , input  logic                       ready_i
   , input  logic [31:0]                instr_i
   , input  logic                       data_v_i
   , input  logic                       miss_v_i
   , input  icache_msg_pkg::cache_req_s cache_req_i
   , input  logic                       cache_req_v_i
   , input  logic                       cache_req_yumi_i
   , input  icache_msg_pkg::fill_pkt_s  fill_pkt_i
   , input  logic                       fill_v_i
   , output int                         errors_o
   , output int                         checks_o
   );

  timeunit 1ns;
  timeprecision 1ps;

  import icache_msg_pkg::*;

  logic [23:0] tag_m [2][16];
  logic        valid_m [2][16];
  logic        lru_m [16];
  logic        lk_v;
  logic [31:0] lk_addr;
  logic        vf_v;
  logic [31:0] vf_addr;
  logic        req_pend;
  logic        busy;
  logic        exp_ready;
  logic [31:0] exp_req_addr;
  logic        exp_req_way;
  logic        exp_hit;
  logic        exp_miss;
  logic        hit_way;
  logic [3:0]  set;

  // Compare one value and count it
  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks_o++;
    if (exp !== act)
    begin
      errors_o++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
    end
  endtask

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < 16; s++)
      begin
        valid_m[0][s] = 1'b0;
        valid_m[1][s] = 1'b0;
        lru_m[s]      = 1'b0;
      end
      lk_v     = 1'b0;
      vf_v     = 1'b0;
      req_pend = 1'b0;
      busy     = 1'b0;
    end
    else
    begin
      // Verify stage of the model
      set     = vf_addr[7:4];
      exp_hit = 1'b0;
      hit_way = 1'b0;
      for (int w = 1; w >= 0; w--)
      begin
        if (vf_v && valid_m[w][set] && (tag_m[w][set] == vf_addr[31:8]))
        begin
          exp_hit = 1'b1;
          hit_way = w[0];
        end
      end
      exp_miss  = vf_v && !exp_hit;
      // Ready only between refills and never in a miss cycle
      exp_ready = !busy && !exp_miss;
      compare($sformatf("data_v %h", vf_addr), 32'(exp_hit), 32'(data_v_i));
      compare($sformatf("miss_v %h", vf_addr), 32'(exp_miss), 32'(miss_v_i));
      compare("ready", 32'(exp_ready), 32'(ready_i));
      compare("req_v", 32'(req_pend), 32'(cache_req_v_i));
      if (exp_hit)
      begin
        compare($sformatf("instr %h", vf_addr), {vf_addr[31:2], 2'b00} ^ pattern_key, instr_i);
        lru_m[set] = ~hit_way;
      end
      if (exp_miss)
      begin
        req_pend     = 1'b1;
        busy         = 1'b1;
        exp_req_addr = {vf_addr[31:4], 4'h0};
        if (!valid_m[0][set])
          exp_req_way = 1'b0;
        else if (!valid_m[1][set])
          exp_req_way = 1'b1;
        else
          exp_req_way = lru_m[set];
      end

      if (cache_req_v_i && cache_req_yumi_i)
      begin
        if (!req_pend)
        begin
          errors_o++;
          $display("Refill request seen without a preceding miss");
        end
        compare("req addr", exp_req_addr, cache_req_i.addr);
        compare("req way", 32'(exp_req_way), 32'(cache_req_i.way));
        req_pend = 1'b0;
      end

      if (fill_v_i)
      begin
        valid_m[fill_pkt_i.way][fill_pkt_i.index] = (fill_pkt_i.op == e_fill_line);
        if (fill_pkt_i.op == e_fill_line)
        begin
          tag_m[fill_pkt_i.way][fill_pkt_i.index] = fill_pkt_i.tag;
          busy = 1'b0;
        end
      end

      // A miss squashes the fetch in lookup
      vf_v    = lk_v && !exp_miss;
      vf_addr = lk_addr;
      lk_v    = fetch_v_i && exp_ready;
      lk_addr = fetch_pkt_i.addr;
    end
  end

  initial
  begin
    errors_o = 0;
    checks_o = 0;
  end

endmodule

`default_nettype wire

//--- tests/icache_sva.sv
// Bound assertions on the refill handshake, result strobes, fill strobe and reset
`default_nettype none

module icache_sva
  (input  logic                        clk_i
   , input  logic                      reset_i
   , input  logic                      ready_o
   , input  logic                      data_v_o
   , input  logic                      miss_v_o
   , input  icache_msg_pkg::cache_req_s cache_req_o
   , input  logic                      cache_req_v_o
   , input  logic                      cache_req_yumi_i
   , input  icache_msg_pkg::fill_pkt_s  fill_pkt_i
   , input  logic                      fill_v_i
   );

  timeunit 1ns;
  timeprecision 1ps;

  import icache_msg_pkg::*;

  int fail_count = 0;

  // Request held until yumi
  req_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (cache_req_v_o && !cache_req_yumi_i) |=> (cache_req_v_o && $stable(cache_req_o)))
  else
  begin
    $error("refill request changed before yumi");
    fail_count++;
  end

  one_result_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(data_v_o && miss_v_o))
  else
  begin
    $error("data_v_o and miss_v_o high together");
    fail_count++;
  end

  fill_when_busy_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (fill_v_i && (fill_pkt_i.op == e_fill_line)) |-> !ready_o)
  else
  begin
    $error("line fill arrived while ready_o was high");
    fail_count++;
  end

  ready_after_reset_a: assert property (@(posedge clk_i)
    $fell(reset_i) |-> ready_o)
  else
  begin
    $error("ready_o low in the first cycle after reset");
    fail_count++;
  end

endmodule

bind icache_top icache_sva sva
  (.clk_i           (clk_i)
   ,.reset_i         (reset_i)
   ,.ready_o         (ready_o)
   ,.data_v_o        (data_v_o)
   ,.miss_v_o        (miss_v_o)
   ,.cache_req_o     (cache_req_o)
   ,.cache_req_v_o   (cache_req_v_o)
   ,.cache_req_yumi_i(cache_req_yumi_i)
   ,.fill_pkt_i      (fill_pkt_i)
   ,.fill_v_i        (fill_v_i)
   );

`default_nettype wire

//--- icache/icache_top.sv
// Instruction cache top level: tag lookup, data array and tag verify
`default_nettype none
`include "icache_defines.svh"

module icache_top
  (input  logic                                clk_i
   , input  logic                              reset_i

   // Fetch port
   , input  icache_msg_pkg::fetch_pkt_s        fetch_pkt_i
   , input  logic                              fetch_v_i
   , output logic                              ready_o

   // Result, two cycles after acceptance
   , output icache_cfg_pkg::instr_t            instr_o
   , output logic                              data_v_o
   , output logic                              miss_v_o

   // Refill request, held until yumi
   , output icache_msg_pkg::cache_req_s        cache_req_o
   , output logic                              cache_req_v_o
   , input  logic                              cache_req_yumi_i

   // Fill strobe
   , input  icache_msg_pkg::fill_pkt_s         fill_pkt_i
   , input  logic                              fill_v_i
   );

  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;

  lookup_s                   lookup;
  logic                      lookup_v;
  logic                      kill;
  logic                      rd_v;
  index_t                    rd_index;
  block_t [`ICACHE_WAYS-1:0] blocks;

  icache_tag_lookup tag_lookup
    (.clk_i       (clk_i)
     ,.reset_i    (reset_i)
     ,.fetch_pkt_i(fetch_pkt_i)
     ,.fetch_v_i  (fetch_v_i)
     ,.ready_i    (ready_o)
     ,.kill_i     (kill)
     ,.fill_pkt_i (fill_pkt_i)
     ,.fill_v_i   (fill_v_i)
     ,.lookup_o   (lookup)
     ,.lookup_v_o (lookup_v)
     ,.rd_v_o     (rd_v)
     ,.rd_index_o (rd_index)
     );

  icache_data_array data_array
    (.clk_i      (clk_i)
     ,.rd_v_i    (rd_v)
     ,.rd_index_i(rd_index)
     ,.fill_pkt_i(fill_pkt_i)
     ,.fill_v_i  (fill_v_i)
     ,.blocks_o  (blocks)
     );

  icache_tag_verify tag_verify
    (.clk_i            (clk_i)
     ,.reset_i         (reset_i)
     ,.lookup_i        (lookup)
     ,.lookup_v_i      (lookup_v)
     ,.blocks_i        (blocks)
     ,.ready_o         (ready_o)
     ,.kill_o          (kill)
     ,.instr_o         (instr_o)
     ,.data_v_o        (data_v_o)
     ,.miss_v_o        (miss_v_o)
     ,.cache_req_o     (cache_req_o)
     ,.cache_req_v_o   (cache_req_v_o)
     ,.cache_req_yumi_i(cache_req_yumi_i)
     ,.fill_pkt_i      (fill_pkt_i)
     ,.fill_v_i        (fill_v_i)
     );

endmodule

`default_nettype wire

//--- icache/icache_tag_verify.sv
// Verify stage, instruction select, LRU bits, replacement choice and refill FSM
`default_nettype none
`include "icache_defines.svh"

module icache_tag_verify
  (input  logic                                       clk_i
   , input  logic                                     reset_i
   , input  icache_msg_pkg::lookup_s                  lookup_i
   , input  logic                                     lookup_v_i
   , input  icache_cfg_pkg::block_t [`ICACHE_WAYS-1:0] blocks_i
   , output logic                                     ready_o
   , output logic                                     kill_o
   , output icache_cfg_pkg::instr_t                   instr_o
   , output logic                                     data_v_o
   , output logic                                     miss_v_o
   , output icache_msg_pkg::cache_req_s               cache_req_o
   , output logic                                     cache_req_v_o
   , input  logic                                     cache_req_yumi_i
   , input  icache_msg_pkg::fill_pkt_s                fill_pkt_i
   , input  logic                                     fill_v_i
   );

  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;

  localparam int unsigned words_per_block = `ICACHE_BLOCK_W / `ICACHE_INSTR_W;

  logic                         tv_v_r;
  lookup_s                      lookup_tv_r;
  block_t [`ICACHE_WAYS-1:0]    blocks_tv_r;
  instr_t [words_per_block-1:0] words;
  logic                         hit;
  logic                         miss;
  index_t                       index_tv;
  way_t                         hit_way;
  way_t                         repl_way;
  way_t                         lru_r [`ICACHE_SETS-1:0];
  cache_state_e                 state_r;
  cache_state_e                 state_n;
  cache_req_s                   req_r;

  //////////////////////////////
  // Verify stage
  //////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tv_v_r <= 1'b0;
    else
      tv_v_r <= lookup_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (lookup_v_i)
    begin
      lookup_tv_r <= lookup_i;
      blocks_tv_r <= blocks_i;
    end
  end

  assign hit      = tv_v_r & lookup_tv_r.any_hit;
  assign miss     = tv_v_r & ~lookup_tv_r.any_hit;
  assign index_tv = paddr_index(lookup_tv_r.addr);
  assign hit_way  = first_way(lookup_tv_r.hit);

  // Hit way block, then the word
  assign words    = blocks_tv_r[hit_way];
  assign instr_o  = words[paddr_woffset(lookup_tv_r.addr)];
  assign data_v_o = hit;
  assign miss_v_o = miss;

  //////////////////////////////
  // Replacement
  //////////////////////////////

  // Points at the way to evict next
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < `ICACHE_SETS; s++)
      begin
        lru_r[s] <= '0;
      end
    end
    else if (hit)
    begin
      lru_r[index_tv] <= ~hit_way;
    end
  end

  // Invalid way wins over LRU
  assign repl_way = (&lookup_tv_r.valid) ? lru_r[index_tv] : first_way(~lookup_tv_r.valid);

  //////////////////////////////
  // Refill FSM
  //////////////////////////////

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_ready:
        if (miss)
          state_n = e_request;
      e_request:
        if (cache_req_yumi_i)
          state_n = e_wait;
      e_wait:
        if (fill_v_i && (fill_pkt_i.op == e_fill_line))
          state_n = e_ready;
      default:
        state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_ready;
    else
      state_r <= state_n;
  end

  // Captured once per miss, stable through the handshake
  always_ff @(posedge clk_i)
  begin
    if (miss)
      req_r <= '{addr: paddr_block(lookup_tv_r.addr), way: repl_way};
  end

  assign cache_req_o   = req_r;
  assign cache_req_v_o = (state_r == e_request);
  assign ready_o       = (state_r == e_ready) & ~miss;
  assign kill_o        = miss;

endmodule

`default_nettype wire

//--- icache/icache_tag_lookup.sv
// Decode stage, tag and valid array, tag compare and the lookup-stage register
`default_nettype none
`include "icache_defines.svh"

module icache_tag_lookup
  (input  logic                          clk_i
   , input  logic                        reset_i
   , input  icache_msg_pkg::fetch_pkt_s  fetch_pkt_i
   , input  logic                        fetch_v_i
   , input  logic                        ready_i
   , input  logic                        kill_i
   , input  icache_msg_pkg::fill_pkt_s   fill_pkt_i
   , input  logic                        fill_v_i
   , output icache_msg_pkg::lookup_s     lookup_o
   , output logic                        lookup_v_o
   // Accepted fetch, for the data array read
   , output logic                        rd_v_o
   , output icache_cfg_pkg::index_t      rd_index_o
   );

  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;

  logic                     accept;
  index_t                   fetch_index;
  logic                     tl_v_r;
  paddr_t                   addr_tl_r;
  ptag_t                    tag_mem [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0];
  way_vec_t                 valid_r [`ICACHE_SETS-1:0];
  ptag_t [`ICACHE_WAYS-1:0] tag_rd_r;
  way_vec_t                 valid_rd_r;
  way_vec_t                 hit_v;

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign accept      = fetch_v_i & ready_i;
  assign fetch_index = paddr_index(fetch_pkt_i.addr);
  assign rd_v_o      = accept;
  assign rd_index_o  = fetch_index;

  //////////////////////////////
  // Tag array
  //////////////////////////////

  // Fill line sets valid, clear way drops it
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < `ICACHE_SETS; s++)
      begin
        valid_r[s] <= '0;
      end
    end
    else if (fill_v_i)
    begin
      valid_r[fill_pkt_i.index][fill_pkt_i.way] <= (fill_pkt_i.op == e_fill_line);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fill_v_i && (fill_pkt_i.op == e_fill_line))
    begin
      tag_mem[fill_pkt_i.way][fill_pkt_i.index] <= fill_pkt_i.tag;
    end
  end

  //////////////////////////////
  // Lookup stage
  //////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tl_v_r <= 1'b0;
    else
      tl_v_r <= accept;
  end

  // Set read and address capture on acceptance
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      addr_tl_r  <= fetch_pkt_i.addr;
      valid_rd_r <= valid_r[fetch_index];
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
        tag_rd_r[w] <= tag_mem[w][fetch_index];
      end
    end
  end

  always_comb
  begin
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      hit_v[w] = valid_rd_r[w] & (tag_rd_r[w] == paddr_tag(addr_tl_r));
    end
  end

  assign lookup_o = '{addr: addr_tl_r, hit: hit_v, valid: valid_rd_r, any_hit: |hit_v};

  // A miss in verify squashes the fetch behind it
  assign lookup_v_o = tl_v_r & ~kill_i;

endmodule

`default_nettype wire

//--- icache/icache_data_array.sv
// Per-way block memories, read on an accepted fetch and written by line fills
`default_nettype none
`include "icache_defines.svh"

module icache_data_array
  (input  logic                                       clk_i
   , input  logic                                     rd_v_i
   , input  icache_cfg_pkg::index_t                   rd_index_i
   , input  icache_msg_pkg::fill_pkt_s                fill_pkt_i
   , input  logic                                     fill_v_i
   , output icache_cfg_pkg::block_t [`ICACHE_WAYS-1:0] blocks_o
   );

  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;

  logic fill_line;

  assign fill_line = fill_v_i & (fill_pkt_i.op == e_fill_line);

  // One full-block bank per way
  for (genvar w = 0; w < `ICACHE_WAYS; w++)
  begin : g_way
    block_t mem [`ICACHE_SETS-1:0];
    block_t rd_r;
    logic   wr_en;

    assign wr_en = fill_line & (fill_pkt_i.way == way_t'(w));

    always_ff @(posedge clk_i)
    begin
      if (wr_en)
        mem[fill_pkt_i.index] <= fill_pkt_i.data;
    end

    // Read data lands in the lookup cycle
    always_ff @(posedge clk_i)
    begin
      if (rd_v_i)
        rd_r <= mem[rd_index_i];
    end

    assign blocks_o[w] = rd_r;
  end

endmodule

`default_nettype wire

//--- common/icache_msg_pkg.sv
// Port message structs plus the fill opcode and request state enums
`default_nettype none

package icache_msg_pkg;
  import icache_cfg_pkg::*;

  //////////////////////////////
  // Enums
  //////////////////////////////

  typedef enum logic [0:0]
  {
    e_fill_line
    , e_clear_way
  } fill_op_e;

  // Refill handshake states
  typedef enum logic [1:0]
  {
    e_ready
    , e_request
    , e_wait
  } cache_state_e;

  //////////////////////////////
  // Messages
  //////////////////////////////

  typedef struct packed
  {
    paddr_t addr;
  } fetch_pkt_s;

  // Tag lookup result handed to verify
  typedef struct packed
  {
    paddr_t   addr;
    way_vec_t hit;
    way_vec_t valid;
    logic     any_hit;
  } lookup_s;

  // Refill request, block aligned
  typedef struct packed
  {
    paddr_t addr;
    way_t   way;
  } cache_req_s;

  typedef struct packed
  {
    fill_op_e op;
    index_t   index;
    way_t     way;
    ptag_t    tag;
    block_t   data;
  } fill_pkt_s;

endpackage

`default_nettype wire

//--- common/icache_cfg_pkg.sv
// Address-field types and helpers that split a physical address
`default_nettype none
`include "icache_defines.svh"

package icache_cfg_pkg;

  // Field widths derived from the geometry
  localparam int unsigned index_w    = $clog2(`ICACHE_SETS);
  localparam int unsigned way_w      = $clog2(`ICACHE_WAYS);
  localparam int unsigned byte_off_w = $clog2(`ICACHE_INSTR_W / 8);
  localparam int unsigned woffset_w  = $clog2(`ICACHE_BLOCK_W / `ICACHE_INSTR_W);
  localparam int unsigned boff_w     = byte_off_w + woffset_w;
  localparam int unsigned tag_w      = `ICACHE_PADDR_W - index_w - boff_w;

  typedef logic [`ICACHE_PADDR_W-1:0] paddr_t;
  typedef logic [tag_w-1:0]           ptag_t;
  typedef logic [index_w-1:0]         index_t;
  typedef logic [woffset_w-1:0]       woffset_t;
  typedef logic [way_w-1:0]           way_t;
  typedef logic [`ICACHE_WAYS-1:0]    way_vec_t;
  typedef logic [`ICACHE_BLOCK_W-1:0] block_t;
  typedef logic [`ICACHE_INSTR_W-1:0] instr_t;

  // Address layout: tag | index | word offset | byte offset
  function automatic ptag_t paddr_tag(paddr_t a);
    return a[`ICACHE_PADDR_W-1 -: tag_w];
  endfunction

  function automatic index_t paddr_index(paddr_t a);
    return a[boff_w +: index_w];
  endfunction

  // Byte bits below the word offset are ignored
  function automatic woffset_t paddr_woffset(paddr_t a);
    return a[byte_off_w +: woffset_w];
  endfunction

  function automatic paddr_t paddr_block(paddr_t a);
    return {a[`ICACHE_PADDR_W-1:boff_w], {boff_w{1'b0}}};
  endfunction

  // Lowest way with its bit set, way 0 when none
  function automatic way_t first_way(way_vec_t v);
    way_t w;
    w = '0;
    for (int i = `ICACHE_WAYS - 1; i >= 0; i--)
    begin
      if (v[i])
        w = way_t'(i);
    end
    return w;
  endfunction

endpackage

`default_nettype wire

//--- common/icache_defines.svh
// Geometry macros for the instruction cache: ways, sets, block, word and address widths
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

//////////////////////////////
// Organization
//////////////////////////////

// 2-way set associative, 16 sets
`define ICACHE_WAYS 2
`define ICACHE_SETS 16

//////////////////////////////
// Widths in bits
//////////////////////////////

`define ICACHE_BLOCK_W 128
`define ICACHE_INSTR_W 32
`define ICACHE_PADDR_W 32

`endif
